// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module exec_backend_tb -o exec_backend_sim
out=$(./obj_dir/exec_backend_sim)
echo "$out"
if grep -qx "Everything OK" <<< "$out"; then
    exit 0
fi
exit 1

// File: sim/clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                      // 4 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;                               // Released away from the rising edge
    end

endmodule

`default_nettype wire

// File: sim/exec_backend_tb.sv
`timescale 1ns/100ps
`default_nettype none

module exec_backend_tb import exec_pkg::*; ();

    localparam int n_bundles      = 2000;
    localparam int timeout_cycles = 2200;           // Bundles plus reset and drain
    localparam logic [xlen-1:0] load_key = 32'h5a5a_a5a5;

    typedef struct packed {
        logic            we;
        reg_idx_t        waddr;
        logic [xlen-1:0] alu;
        logic [xlen-1:0] data;
    } stage_t;

    typedef struct packed {
        logic [31:0] due;
        stage_t      a;
        stage_t      b;
    } expect_t;

    logic            clk;
    logic            rst_n;
    logic            ex_valid [2];
    logic [xlen-1:0] pc [2];
    logic [xlen-1:0] rdata1 [2];
    logic [xlen-1:0] rdata2 [2];
    logic [xlen-1:0] imm [2];
    reg_idx_t        raddr1 [2];
    reg_idx_t        raddr2 [2];
    reg_idx_t        rf_waddr [2];
    logic            rf_we [2];
    src1_e           src1_sel [2];
    src2_e           src2_sel [2];
    alu_op_e         alu_op [2];
    wb_sel_e         wb_sel_b;
    logic            mul_signed_b;
    logic            mem_we_b;
    logic [xlen-1:0] mem_rdata;
    logic            mem_rvalid;
    logic            mem_wvalid;
    logic [xlen-1:0] mem_addr;
    logic [xlen-1:0] mem_wdata;
    logic            wb_rf_we_a;
    logic            wb_rf_we_b;
    reg_idx_t        wb_rf_waddr_a;
    reg_idx_t        wb_rf_waddr_b;
    logic [xlen-1:0] wb_rf_wdata_a;
    logic [xlen-1:0] wb_rf_wdata_b;

    stage_t          mem_st [2];                    // Older bundle now in MEM
    stage_t          wb_st [2];                     // Bundle now in WB
    expect_t         exp_q [$];
    logic            late_b;                        // MEM lane B is a load or multiply
    logic            load_pending;
    logic [xlen-1:0] load_addr;
    logic [xlen-1:0] store_mem [logic [xlen-1:0]];
    int unsigned     cyc = 0;
    int              checks = 0;
    int              errors = 0;
    int              stores = 0;

    clock_gen clock_inst (.clk(clk), .rst_n(rst_n));

    exec_backend exec_backend_inst (
        .clk(clk), .rst_n(rst_n),
        .ex_valid_a(ex_valid[0]), .pc_a(pc[0]), .rdata1_a(rdata1[0]), .rdata2_a(rdata2[0]),
        .raddr1_a(raddr1[0]), .raddr2_a(raddr2[0]), .imm_a(imm[0]),
        .src1_sel_a(src1_sel[0]), .src2_sel_a(src2_sel[0]), .alu_op_a(alu_op[0]),
        .rf_we_a(rf_we[0]), .rf_waddr_a(rf_waddr[0]),
        .ex_valid_b(ex_valid[1]), .pc_b(pc[1]), .rdata1_b(rdata1[1]), .rdata2_b(rdata2[1]),
        .raddr1_b(raddr1[1]), .raddr2_b(raddr2[1]), .imm_b(imm[1]),
        .src1_sel_b(src1_sel[1]), .src2_sel_b(src2_sel[1]), .alu_op_b(alu_op[1]),
        .rf_we_b(rf_we[1]), .rf_waddr_b(rf_waddr[1]),
        .wb_sel_b(wb_sel_b), .mul_signed_b(mul_signed_b), .mem_we_b(mem_we_b),
        .mem_rvalid(mem_rvalid), .mem_wvalid(mem_wvalid), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .wb_rf_we_a(wb_rf_we_a), .wb_rf_we_b(wb_rf_we_b),
        .wb_rf_waddr_a(wb_rf_waddr_a), .wb_rf_waddr_b(wb_rf_waddr_b),
        .wb_rf_wdata_a(wb_rf_wdata_a), .wb_rf_wdata_b(wb_rf_wdata_b)
    );

    // Youngest matching writer supplies the operand
    function automatic logic [xlen-1:0] forward_operand(reg_idx_t idx, logic [xlen-1:0] issued);
        if (idx == reg_zero) return issued;
        if (mem_st[1].we && mem_st[1].waddr == idx) return mem_st[1].alu;
        if (mem_st[0].we && mem_st[0].waddr == idx) return mem_st[0].alu;
        if (wb_st[1].we && wb_st[1].waddr == idx) return wb_st[1].data;
        if (wb_st[0].we && wb_st[0].waddr == idx) return wb_st[0].data;
        return issued;
    endfunction

    function automatic logic [xlen-1:0] alu_model(alu_op_e op, logic [xlen-1:0] a,
                                                  logic [xlen-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            op_add:   return a + b;
            op_sub:   return a + ~b + 32'd1;
            op_slt:   return {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};
            op_sltu:  return {31'b0, a < b};
            op_and:   return a & b;
            op_or:    return a | b;
            op_xor:   return a ^ b;
            op_nor:   return ~a & ~b;
            op_sll:   return a << sh;
            op_srl:   return a >> sh;
            op_sra:   return (a >> sh) | ({32{a[31]}} & ~(32'hffff_ffff >> sh));
            op_pass2: return b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic [63:0] mul_model(logic [xlen-1:0] x, logic [xlen-1:0] y, logic sgn);
        longint sx;
        longint sy;
        sx = sgn ? longint'($signed(x)) : longint'({32'b0, x});
        sy = sgn ? longint'($signed(y)) : longint'({32'b0, y});
        return 64'(sx * sy);                        // Low 64 bits right for both kinds
    endfunction

    // Expected register write of one lane for the bundle now in EX
    function automatic stage_t reference_write(int l);
        logic [xlen-1:0] f1;
        logic [xlen-1:0] f2;
        logic [63:0]     prod;
        stage_t          s;
        f1 = forward_operand(raddr1[l], rdata1[l]);
        f2 = forward_operand(raddr2[l], rdata2[l]);
        prod = mul_model(f1, f2, mul_signed_b);
        s.we = ex_valid[l] && rf_we[l];
        s.waddr = rf_waddr[l];
        s.alu = alu_model(alu_op[l], (src1_sel[l] == src1_pc) ? pc[l] : f1,
                          (src2_sel[l] == src2_imm) ? imm[l] : f2);
        s.data = s.alu;
        if (l == 1 && wb_sel_b == wb_load) s.data = s.alu ^ load_key;
        if (l == 1 && wb_sel_b == wb_mul_lo) s.data = prod[31:0];
        if (l == 1 && wb_sel_b == wb_mul_hi) s.data = prod[63:32];
        return s;
    endfunction

    task automatic report_error(string what);
        errors++;
        $display("[ERROR] %0t: %s", $time, what);
    endtask

    task automatic drive_idle();
        for (int l = 0; l < 2; l++) begin
            ex_valid[l] = 1'b0;
            pc[l] = '0;
            rdata1[l] = '0;
            rdata2[l] = '0;
            imm[l] = '0;
            raddr1[l] = reg_zero;
            raddr2[l] = reg_zero;
            rf_waddr[l] = reg_zero;
            rf_we[l] = 1'b0;
            src1_sel[l] = src1_reg;
            src2_sel[l] = src2_reg;
            alu_op[l] = op_add;
        end
        wb_sel_b = wb_alu;
        mul_signed_b = 1'b0;
        mem_we_b = 1'b0;
    endtask

    task automatic randomize_bundle();
        for (int l = 0; l < 2; l++) begin
            ex_valid[l] = ($urandom_range(7) != 0);
            pc[l] = $urandom;
            rdata1[l] = $urandom;
            rdata2[l] = $urandom;
            imm[l] = $urandom;
            raddr1[l] = reg_idx_t'($urandom_range(7));   // Few registers give many hazards
            raddr2[l] = reg_idx_t'($urandom_range(7));
            rf_waddr[l] = reg_idx_t'($urandom_range(7, 1));
            rf_we[l] = ($urandom_range(5) != 0);
            src1_sel[l] = src1_e'(1'($urandom_range(1)));
            src2_sel[l] = src2_e'(1'($urandom_range(1)));
            alu_op[l] = alu_op_e'(4'($urandom_range(11)));
        end
        wb_sel_b = wb_sel_e'(2'($urandom_range(3)));
        mul_signed_b = 1'($urandom_range(1));
        mem_we_b = (wb_sel_b == wb_alu) && ($urandom_range(3) == 0);
        if (mem_we_b) rf_we[1] = 1'b0;              // Stores write no register
        // Issue rules forbid reading a late lane B result and lane A to B pairs
        for (int l = 0; l < 2; l++) begin
            if (late_b && raddr1[l] == mem_st[1].waddr) raddr1[l] = reg_zero;
            if (late_b && raddr2[l] == mem_st[1].waddr) raddr2[l] = reg_zero;
        end
        if (ex_valid[0] && rf_we[0] && raddr1[1] == rf_waddr[0]) raddr1[1] = reg_zero;
        if (ex_valid[0] && rf_we[0] && raddr2[1] == rf_waddr[0]) raddr2[1] = reg_zero;
    endtask

    task automatic check_quiet();
        checks++;
        if ({wb_rf_we_a, wb_rf_we_b, mem_rvalid, mem_wvalid} !== 4'b0)
            report_error("write enable or memory strobe active around reset");
    endtask

    task automatic run_bundle();
        stage_t          res_a;
        stage_t          res_b;
        logic [xlen-1:0] store_exp;
        logic            exp_r;
        logic            exp_w;
        if (load_pending) mem_rdata = load_addr ^ load_key;   // Load data during MEM
        load_pending = 1'b0;
        randomize_bundle();
        res_a = reference_write(0);
        res_b = reference_write(1);
        store_exp = forward_operand(raddr2[1], rdata2[1]);
        exp_q.push_back('{due: cyc + 2, a: res_a, b: res_b});
        wb_st = mem_st;
        mem_st[0] = res_a;
        mem_st[1] = res_b;
        late_b = res_b.we && (wb_sel_b != wb_alu);
        exp_r = ex_valid[1] && (wb_sel_b == wb_load);
        exp_w = ex_valid[1] && mem_we_b;
        #1;
        checks++;
        if (mem_rvalid !== exp_r || mem_wvalid !== exp_w)
            report_error($sformatf("memory strobes r=%b w=%b, expected r=%b w=%b",
                                   mem_rvalid, mem_wvalid, exp_r, exp_w));
        if ((exp_r || exp_w) && mem_addr !== res_b.alu)
            report_error($sformatf("mem_addr %h, expected %h", mem_addr, res_b.alu));
        if (exp_w && mem_wdata !== store_exp)
            report_error($sformatf("mem_wdata %h, expected %h", mem_wdata, store_exp));
        load_pending = mem_rvalid;
        load_addr = mem_addr;
        if (mem_wvalid) begin
            store_mem[mem_addr] = mem_wdata;
            stores++;
        end
    endtask

    task automatic compare_lane(string name, stage_t exp, logic we, reg_idx_t waddr,
                                logic [xlen-1:0] wdata);
        checks++;
        if (we !== exp.we)
            report_error($sformatf("%s write enable %b, expected %b", name, we, exp.we));
        else if (exp.we && (waddr !== exp.waddr || wdata !== exp.data))
            report_error($sformatf("%s wrote r%0d=%h, expected r%0d=%h",
                                   name, waddr, wdata, exp.waddr, exp.data));
    endtask

    // WB outputs settle well before the falling edge
    always @(negedge clk) begin
        if (exp_q.size() != 0 && exp_q[0].due == cyc) begin
            compare_lane("lane A", exp_q[0].a, wb_rf_we_a, wb_rf_waddr_a, wb_rf_wdata_a);
            compare_lane("lane B", exp_q[0].b, wb_rf_we_b, wb_rf_waddr_b, wb_rf_wdata_b);
            void'(exp_q.pop_front());
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the run did not finish", cyc);
            $display("Something failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h738267ed));
        drive_idle();
        ex_valid[0] = 1'b1;                         // Writing lanes that reset must hold off
        ex_valid[1] = 1'b1;
        rf_we[0] = 1'b1;
        rf_we[1] = 1'b1;
        rf_waddr[0] = reg_idx_t'(1);
        rf_waddr[1] = reg_idx_t'(2);
        mem_rdata = '0;
        mem_st[0] = '0;
        mem_st[1] = '0;
        wb_st[0] = '0;
        wb_st[1] = '0;
        late_b = 1'b0;
        load_pending = 1'b0;
        load_addr = '0;
        repeat (5) begin
            @(negedge clk);
            check_quiet();                          // Reset cycles
        end
        drive_idle();
        @(negedge clk);
        check_quiet();                              // First cycle after reset
        for (int k = 0; k < n_bundles; k++) begin
            run_bundle();
            @(negedge clk);
        end
        if (load_pending) mem_rdata = load_addr ^ load_key;
        drive_idle();
        repeat (3) @(negedge clk);
        if (exp_q.size() != 0)
            report_error($sformatf("%0d expected writes never reached WB", exp_q.size()));
        $display("Checks: %0d  errors: %0d  stores: %0d  store addresses: %0d",
                 checks, errors, stores, store_mem.num());
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
verilog/exec_pkg.sv
verilog/operand_forward.sv
verilog/int_alu.sv
verilog/mul_unit.sv
verilog/lane_pipeline.sv
verilog/exec_backend.sv
sim/clock_gen.sv
sim/exec_backend_tb.sv

// File: verilog/exec_backend.sv
`timescale 1ns/100ps
`default_nettype none

module exec_backend import exec_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            ex_valid_a,
    input  wire logic [xlen-1:0] pc_a,
    input  wire logic [xlen-1:0] rdata1_a,
    input  wire logic [xlen-1:0] rdata2_a,
    input  wire reg_idx_t        raddr1_a,
    input  wire reg_idx_t        raddr2_a,
    input  wire logic [xlen-1:0] imm_a,
    input  wire src1_e           src1_sel_a,
    input  wire src2_e           src2_sel_a,
    input  wire alu_op_e         alu_op_a,
    input  wire logic            rf_we_a,
    input  wire reg_idx_t        rf_waddr_a,
    input  wire logic            ex_valid_b,
    input  wire logic [xlen-1:0] pc_b,
    input  wire logic [xlen-1:0] rdata1_b,
    input  wire logic [xlen-1:0] rdata2_b,
    input  wire reg_idx_t        raddr1_b,
    input  wire reg_idx_t        raddr2_b,
    input  wire logic [xlen-1:0] imm_b,
    input  wire src1_e           src1_sel_b,
    input  wire src2_e           src2_sel_b,
    input  wire alu_op_e         alu_op_b,
    input  wire logic            rf_we_b,
    input  wire reg_idx_t        rf_waddr_b,
    input  wire wb_sel_e         wb_sel_b,         // wb_load marks a load
    input  wire logic            mul_signed_b,
    input  wire logic            mem_we_b,         // Store
    output logic                 mem_rvalid,
    output logic                 mem_wvalid,
    output logic      [xlen-1:0] mem_addr,
    output logic      [xlen-1:0] mem_wdata,
    input  wire logic [xlen-1:0] mem_rdata,        // Valid in the MEM cycle
    output logic                 wb_rf_we_a,
    output logic                 wb_rf_we_b,
    output reg_idx_t             wb_rf_waddr_a,
    output reg_idx_t             wb_rf_waddr_b,
    output logic      [xlen-1:0] wb_rf_wdata_a,
    output logic      [xlen-1:0] wb_rf_wdata_b
);

    logic [xlen-1:0] fwd_a1;
    logic [xlen-1:0] fwd_a2;
    logic [xlen-1:0] fwd_b1;
    logic [xlen-1:0] fwd_b2;
    logic [xlen-1:0] alu_result_a;
    logic [xlen-1:0] alu_result_b;
    logic [xlen-1:0] mul_lo;
    logic [xlen-1:0] mul_hi;
    logic            mem_rf_we_a;
    logic            mem_rf_we_b;
    reg_idx_t        mem_rf_waddr_a;
    reg_idx_t        mem_rf_waddr_b;
    logic [xlen-1:0] mem_alu_result_a;
    logic [xlen-1:0] mem_alu_result_b;

    operand_forward forward_inst (
        .rdata_a1(rdata1_a), .rdata_a2(rdata2_a), .rdata_b1(rdata1_b), .rdata_b2(rdata2_b),
        .raddr_a1(raddr1_a), .raddr_a2(raddr2_a), .raddr_b1(raddr1_b), .raddr_b2(raddr2_b),
        .mem_rf_we_a(mem_rf_we_a), .mem_rf_we_b(mem_rf_we_b),
        .mem_rf_waddr_a(mem_rf_waddr_a), .mem_rf_waddr_b(mem_rf_waddr_b),
        .mem_alu_result_a(mem_alu_result_a), .mem_alu_result_b(mem_alu_result_b),
        .wb_rf_we_a(wb_rf_we_a), .wb_rf_we_b(wb_rf_we_b),
        .wb_rf_waddr_a(wb_rf_waddr_a), .wb_rf_waddr_b(wb_rf_waddr_b),
        .wb_rf_wdata_a(wb_rf_wdata_a), .wb_rf_wdata_b(wb_rf_wdata_b),
        .fwd_a1(fwd_a1), .fwd_a2(fwd_a2), .fwd_b1(fwd_b1), .fwd_b2(fwd_b2)
    );

    int_alu alu_a (
        .pc(pc_a), .rdata1(fwd_a1), .rdata2(fwd_a2), .imm(imm_a),
        .src1_sel(src1_sel_a), .src2_sel(src2_sel_a), .alu_op(alu_op_a),
        .result(alu_result_a)
    );

    int_alu alu_b (
        .pc(pc_b), .rdata1(fwd_b1), .rdata2(fwd_b2), .imm(imm_b),
        .src1_sel(src1_sel_b), .src2_sel(src2_sel_b), .alu_op(alu_op_b),
        .result(alu_result_b)
    );

    // Multiplies use the forwarded register operands of lane B
    mul_unit mul_inst (
        .clk(clk), .rst_n(rst_n), .x(fwd_b1), .y(fwd_b2), .mul_signed(mul_signed_b),
        .product_lo(mul_lo), .product_hi(mul_hi)
    );

    lane_pipeline pipe_inst (
        .clk(clk), .rst_n(rst_n), .ex_valid_a(ex_valid_a), .ex_valid_b(ex_valid_b),
        .rf_we_a(rf_we_a), .rf_we_b(rf_we_b), .rf_waddr_a(rf_waddr_a), .rf_waddr_b(rf_waddr_b),
        .alu_result_a(alu_result_a), .alu_result_b(alu_result_b), .store_data(fwd_b2),
        .wb_sel_b(wb_sel_b), .mem_we_b(mem_we_b), .mul_lo(mul_lo), .mul_hi(mul_hi),
        .mem_rdata(mem_rdata), .mem_rvalid(mem_rvalid), .mem_wvalid(mem_wvalid),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_rf_we_a(mem_rf_we_a), .mem_rf_we_b(mem_rf_we_b),
        .mem_rf_waddr_a(mem_rf_waddr_a), .mem_rf_waddr_b(mem_rf_waddr_b),
        .mem_alu_result_a(mem_alu_result_a), .mem_alu_result_b(mem_alu_result_b),
        .wb_rf_we_a(wb_rf_we_a), .wb_rf_we_b(wb_rf_we_b),
        .wb_rf_waddr_a(wb_rf_waddr_a), .wb_rf_waddr_b(wb_rf_waddr_b),
        .wb_rf_wdata_a(wb_rf_wdata_a), .wb_rf_wdata_b(wb_rf_wdata_b)
    );

endmodule

`default_nettype wire

// File: verilog/exec_pkg.sv
`default_nettype none

package exec_pkg;

    localparam int xlen      = 32;                  // Data and address width
    localparam int reg_idx_w = 5;                   // 32 architectural registers
    localparam int prod_w    = 2 * xlen;            // Full multiplier product

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    localparam reg_idx_t reg_zero = '0;             // Hardwired zero, never forwarded

    typedef enum logic [3:0] {
        op_add   = 4'd0,
        op_sub   = 4'd1,
        op_slt   = 4'd2,                            // Signed compare
        op_sltu  = 4'd3,                            // Unsigned compare
        op_and   = 4'd4,
        op_or    = 4'd5,
        op_xor   = 4'd6,
        op_nor   = 4'd7,
        op_sll   = 4'd8,
        op_srl   = 4'd9,
        op_sra   = 4'd10,
        op_pass2 = 4'd11                            // Upper-immediate loads
    } alu_op_e;

    typedef enum logic {
        src1_reg = 1'b0,
        src1_pc  = 1'b1
    } src1_e;

    typedef enum logic {
        src2_reg = 1'b0,
        src2_imm = 1'b1
    } src2_e;

    // Lane B result source, picked in MEM
    typedef enum logic [1:0] {
        wb_alu    = 2'd0,
        wb_load   = 2'd1,
        wb_mul_lo = 2'd2,
        wb_mul_hi = 2'd3
    } wb_sel_e;

endpackage

`default_nettype wire

// File: verilog/int_alu.sv
`timescale 1ns/100ps
`default_nettype none

module int_alu import exec_pkg::*; (
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] rdata1,
    input  wire logic [xlen-1:0] rdata2,
    input  wire logic [xlen-1:0] imm,
    input  wire src1_e           src1_sel,
    input  wire src2_e           src2_sel,
    input  wire alu_op_e         alu_op,
    output logic      [xlen-1:0] result
);

    logic [xlen-1:0] op1;
    logic [xlen-1:0] op2;
    logic [4:0]      shamt;

    assign op1   = (src1_sel == src1_pc) ? pc : rdata1;
    assign op2   = (src2_sel == src2_imm) ? imm : rdata2;
    assign shamt = op2[4:0];                        // Only low 5 bits count

    always_comb begin
        case (alu_op)
            op_add: begin
                result = op1 + op2;
            end
            op_sub: begin
                result = op1 - op2;
            end
            op_slt: begin
                result = {{(xlen-1){1'b0}}, $signed(op1) < $signed(op2)};
            end
            op_sltu: begin
                result = {{(xlen-1){1'b0}}, op1 < op2};
            end
            op_and: begin
                result = op1 & op2;
            end
            op_or: begin
                result = op1 | op2;
            end
            op_xor: begin
                result = op1 ^ op2;
            end
            op_nor: begin
                result = ~(op1 | op2);
            end
            op_sll: begin
                result = op1 << shamt;
            end
            op_srl: begin
                result = op1 >> shamt;
            end
            op_sra: begin
                result = $unsigned($signed(op1) >>> shamt);
            end
            op_pass2: begin
                result = op2;                       // lu12i style
            end
            default: begin
                result = '0;                        // Unused encodings
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/lane_pipeline.sv
`timescale 1ns/100ps
`default_nettype none

module lane_pipeline import exec_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic            ex_valid_a,
    input  wire logic            ex_valid_b,
    input  wire logic            rf_we_a,
    input  wire logic            rf_we_b,
    input  wire reg_idx_t        rf_waddr_a,
    input  wire reg_idx_t        rf_waddr_b,
    input  wire logic [xlen-1:0] alu_result_a,
    input  wire logic [xlen-1:0] alu_result_b,
    input  wire logic [xlen-1:0] store_data,
    input  wire wb_sel_e         wb_sel_b,
    input  wire logic            mem_we_b,
    input  wire logic [xlen-1:0] mul_lo,
    input  wire logic [xlen-1:0] mul_hi,
    input  wire logic [xlen-1:0] mem_rdata,
    output logic                 mem_rvalid,
    output logic                 mem_wvalid,
    output logic      [xlen-1:0] mem_addr,
    output logic      [xlen-1:0] mem_wdata,
    output logic                 mem_rf_we_a,
    output logic                 mem_rf_we_b,
    output reg_idx_t             mem_rf_waddr_a,
    output reg_idx_t             mem_rf_waddr_b,
    output logic      [xlen-1:0] mem_alu_result_a,
    output logic      [xlen-1:0] mem_alu_result_b,
    output logic                 wb_rf_we_a,
    output logic                 wb_rf_we_b,
    output reg_idx_t             wb_rf_waddr_a,
    output reg_idx_t             wb_rf_waddr_b,
    output logic      [xlen-1:0] wb_rf_wdata_a,
    output logic      [xlen-1:0] wb_rf_wdata_b
);

    wb_sel_e         mem_wb_sel_b;                  // Lane B result source in MEM
    logic [xlen-1:0] mem_wdata_b;

    // Data memory request, lane B only
    assign mem_rvalid = ex_valid_b && (wb_sel_b == wb_load);
    assign mem_wvalid = ex_valid_b && mem_we_b;
    assign mem_addr   = alu_result_b;
    assign mem_wdata  = store_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_rf_we_a <= 1'b0;
            mem_rf_we_b <= 1'b0;
            wb_rf_we_a  <= 1'b0;
            wb_rf_we_b  <= 1'b0;
        end else begin
            mem_rf_we_a <= ex_valid_a && rf_we_a;  // Idle lanes never write
            mem_rf_we_b <= ex_valid_b && rf_we_b;
            wb_rf_we_a  <= mem_rf_we_a;
            wb_rf_we_b  <= mem_rf_we_b;
        end
    end

    always_ff @(posedge clk) begin
        mem_rf_waddr_a   <= rf_waddr_a;
        mem_rf_waddr_b   <= rf_waddr_b;
        mem_alu_result_a <= alu_result_a;
        mem_alu_result_b <= alu_result_b;
        mem_wb_sel_b     <= wb_sel_b;
        wb_rf_waddr_a    <= mem_rf_waddr_a;
        wb_rf_waddr_b    <= mem_rf_waddr_b;
        wb_rf_wdata_a    <= mem_alu_result_a;       // Lane A is ALU only
        wb_rf_wdata_b    <= mem_wdata_b;
    end

    always_comb begin
        case (mem_wb_sel_b)
            wb_load:   mem_wdata_b = mem_rdata;     // Memory answers during MEM
            wb_mul_lo: mem_wdata_b = mul_lo;
            wb_mul_hi: mem_wdata_b = mul_hi;
            default:   mem_wdata_b = mem_alu_result_b;
        endcase
    end

    a_load_store_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_rvalid && mem_wvalid))
        else $error("lane B issued as load and store at once");

    a_no_we_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(mem_rf_we_a || mem_rf_we_b || wb_rf_we_a || wb_rf_we_b))
        else $error("register write enable raised during reset");

endmodule

`default_nettype wire

// File: verilog/mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mul_unit import exec_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rst_n,
    input  wire logic [xlen-1:0] x,
    input  wire logic [xlen-1:0] y,
    input  wire logic            mul_signed,
    output logic      [xlen-1:0] product_lo,
    output logic      [xlen-1:0] product_hi
);

    logic signed [xlen:0]     x_ext;                // 33 bits covers both signednesses
    logic signed [xlen:0]     y_ext;
    logic signed [16:0]       y_lo;
    logic signed [xlen-16:0]  y_hi;
    logic signed [prod_w-1:0] part_lo;
    logic signed [prod_w-1:0] part_hi;
    logic signed [prod_w-1:0] part_lo_q;
    logic signed [prod_w-1:0] part_hi_q;
    logic        [prod_w-1:0] product;

    assign x_ext = {mul_signed & x[xlen-1], x};
    assign y_ext = {mul_signed & y[xlen-1], y};
    assign y_lo  = {1'b0, y_ext[15:0]};             // Low half is always unsigned
    assign y_hi  = y_ext[xlen:16];                  // Carries the sign

    // EX: two partial sums, the upper one already aligned
    assign part_lo = x_ext * y_lo;
    assign part_hi = (x_ext * y_hi) <<< 16;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            part_lo_q <= '0;
            part_hi_q <= '0;
        end else begin
            part_lo_q <= part_lo;
            part_hi_q <= part_hi;
        end
    end

    // MEM: final add, upper bits beyond 64 drop out
    assign product    = part_lo_q + part_hi_q;
    assign product_lo = product[xlen-1:0];
    assign product_hi = product[prod_w-1:xlen];

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
`timescale 1ns/100ps
`default_nettype none

module operand_forward import exec_pkg::*; (
    input  wire logic [xlen-1:0] rdata_a1,
    input  wire logic [xlen-1:0] rdata_a2,
    input  wire logic [xlen-1:0] rdata_b1,
    input  wire logic [xlen-1:0] rdata_b2,
    input  wire reg_idx_t        raddr_a1,
    input  wire reg_idx_t        raddr_a2,
    input  wire reg_idx_t        raddr_b1,
    input  wire reg_idx_t        raddr_b2,
    input  wire logic            mem_rf_we_a,
    input  wire logic            mem_rf_we_b,
    input  wire reg_idx_t        mem_rf_waddr_a,
    input  wire reg_idx_t        mem_rf_waddr_b,
    input  wire logic [xlen-1:0] mem_alu_result_a,
    input  wire logic [xlen-1:0] mem_alu_result_b,
    input  wire logic            wb_rf_we_a,
    input  wire logic            wb_rf_we_b,
    input  wire reg_idx_t        wb_rf_waddr_a,
    input  wire reg_idx_t        wb_rf_waddr_b,
    input  wire logic [xlen-1:0] wb_rf_wdata_a,
    input  wire logic [xlen-1:0] wb_rf_wdata_b,
    output logic      [xlen-1:0] fwd_a1,
    output logic      [xlen-1:0] fwd_a2,
    output logic      [xlen-1:0] fwd_b1,
    output logic      [xlen-1:0] fwd_b2
);

    logic [xlen-1:0] issued [4];
    reg_idx_t        idx    [4];
    logic [xlen-1:0] fwd    [4];

    assign issued[0] = rdata_a1;
    assign issued[1] = rdata_a2;
    assign issued[2] = rdata_b1;
    assign issued[3] = rdata_b2;
    assign idx[0]    = raddr_a1;
    assign idx[1]    = raddr_a2;
    assign idx[2]    = raddr_b1;
    assign idx[3]    = raddr_b2;

    // Youngest writer first: MEM before WB, lane B before lane A
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            if (idx[i] == reg_zero)
                fwd[i] = issued[i];
            else if (mem_rf_we_b && mem_rf_waddr_b == idx[i])
                fwd[i] = mem_alu_result_b;
            else if (mem_rf_we_a && mem_rf_waddr_a == idx[i])
                fwd[i] = mem_alu_result_a;
            else if (wb_rf_we_b && wb_rf_waddr_b == idx[i])
                fwd[i] = wb_rf_wdata_b;
            else if (wb_rf_we_a && wb_rf_waddr_a == idx[i])
                fwd[i] = wb_rf_wdata_a;
            else
                fwd[i] = issued[i];                 // Register file copy is current
        end
    end

    assign fwd_a1 = fwd[0];
    assign fwd_a2 = fwd[1];
    assign fwd_b1 = fwd[2];
    assign fwd_b2 = fwd[3];

endmodule

`default_nettype wire
